// File: tb.f
source/mips_isa_pkg.sv
source/id_stage_pkg.sv
source/id_decoder.sv
source/id_operand_select.sv
source/id_branch_unit.sv
source/id_ex_register.sv
source/id_stage.sv
testbench/clock_gen.sv
testbench/id_stage_checker.sv
testbench/id_stage_tb.sv

// File: Bender.yml
package:
  name: id_stage

sources:
  - files:
      - source/mips_isa_pkg.sv
      - source/id_stage_pkg.sv
      - source/id_decoder.sv
      - source/id_operand_select.sv
      - source/id_branch_unit.sv
      - source/id_ex_register.sv
      - source/id_stage.sv
  - target: test
    files:
      - testbench/clock_gen.sv
      - testbench/id_stage_checker.sv
      - testbench/id_stage_tb.sv

// File: testbench/id_stage_tb.sv
`timescale 1ns/1ps

module id_stage_tb;
	import mips_isa_pkg::*;
	import id_stage_pkg::*;

	// tests take about 170 cycles
	localparam int timeout_cycles = 400;
	localparam int decode_rounds  = 6;

	logic       clk;
	logic       reset;
	word_t      pc;
	word_t      inst;
	word_t      reg1_data;
	word_t      reg2_data;
	fwd_t       ex_fwd;
	fwd_t       mem_fwd;
	aluop_e     ex_aluop;
	logic       in_delay_slot;
	rf_req_t    rf1;
	rf_req_t    rf2;
	logic       stall;
	logic       branch_flag;
	word_t      branch_target;
	logic       next_in_delay_slot;
	ex_bundle_t ex_out;
	int         cycles = 0;

	clock_gen clock_gen_i (
		.clk_o   (clk),
		.reset_o (reset)
	);

	id_stage dut_i (
		.clk_i                (clk),
		.reset_i              (reset),
		.pc_i                 (pc),
		.inst_i               (inst),
		.reg1_data_i          (reg1_data),
		.reg2_data_i          (reg2_data),
		.ex_fwd_i             (ex_fwd),
		.mem_fwd_i            (mem_fwd),
		.ex_aluop_i           (ex_aluop),
		.in_delay_slot_i      (in_delay_slot),
		.rf1_o                (rf1),
		.rf2_o                (rf2),
		.stall_o              (stall),
		.branch_flag_o        (branch_flag),
		.branch_target_o      (branch_target),
		.next_in_delay_slot_o (next_in_delay_slot),
		.ex_o                 (ex_out)
	);

	//////////////////////////////////////////////////
	// register file model
	function automatic word_t rf_value(reg_addr_t r);
		return word_t'(r) * 32'h01010101;
	endfunction

	assign reg1_data = rf_value(rf1.addr);
	assign reg2_data = rf_value(rf2.addr);

	function automatic word_t r_inst(funct_e fn, reg_addr_t rs, reg_addr_t rt, reg_addr_t rd,
			logic [4:0] sa);
		return {OP_SPECIAL, rs, rt, rd, sa, fn};
	endfunction

	function automatic word_t i_inst(opcode_e op, reg_addr_t rs, reg_addr_t rt,
			logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t sign_ext16(logic [15:0] v);
		return {{16{v[15]}}, v};
	endfunction

	function automatic reg_addr_t random_reg();
		return reg_addr_t'($urandom);
	endfunction

	task automatic check_value(input string name, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			$display("ERROR time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
			$display("Simulation failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		@(negedge clk);
	endtask

	task automatic check_ex(input aluop_e aluop, input alusel_e alusel, input logic wreg,
			input reg_addr_t wd, input word_t reg1);
		check_value("ex_o.aluop", aluop, ex_out.aluop);
		check_value("ex_o.alusel", alusel, ex_out.alusel);
		check_value("ex_o.wreg", wreg, ex_out.wreg);
		check_value("ex_o.wd", wd, ex_out.wd);
		check_value("ex_o.reg1", reg1, ex_out.reg1);
	endtask

	// combinational outputs checked just before the edge
	task automatic check_branch(input logic taken, input word_t target);
		@(posedge clk);
		check_value("branch_flag_o", taken, branch_flag);
		check_value("next_in_delay_slot_o", 1'b1, next_in_delay_slot);
		if (taken) begin
			check_value("branch_target_o", target, branch_target);
		end
		@(negedge clk);
	endtask

	task automatic clear_forwarding();
		ex_fwd   = '0;
		mem_fwd  = '0;
		ex_aluop = ALU_NOP;
	endtask

	//////////////////////////////////////////////////
	// tests
	task automatic test_reset();
		check_value("ex_o.wreg", 1'b0, ex_out.wreg);
		check_value("ex_o.aluop", ALU_NOP, ex_out.aluop);
	endtask

	task automatic test_r_form(input funct_e fn, input aluop_e aluop, input alusel_e alusel);
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t rd;
		rs   = random_reg();
		rt   = random_reg();
		rd   = random_reg();
		inst = r_inst(fn, rs, rt, rd, 5'd0);
		next_cycle();
		// inst is still held, so the read requests belong to it
		check_value("rf1_o", {1'b1, rs}, rf1);
		check_value("rf2_o", {1'b1, rt}, rf2);
		check_ex(aluop, alusel, 1'b1, rd, rf_value(rs));
		check_value("ex_o.reg2", rf_value(rt), ex_out.reg2);
	endtask

	task automatic test_const_shift(input funct_e fn, input aluop_e aluop);
		reg_addr_t  rt;
		reg_addr_t  rd;
		logic [4:0] sa;
		rt   = random_reg();
		rd   = random_reg();
		sa   = 5'($urandom);
		inst = r_inst(fn, 5'd0, rt, rd, sa);
		next_cycle();
		check_value("rf1_o.read", 1'b0, rf1.read);
		check_ex(aluop, SEL_SHIFT, 1'b1, rd, word_t'(sa));
		check_value("ex_o.reg2", rf_value(rt), ex_out.reg2);
	endtask

	task automatic test_imm_form(input opcode_e op, input aluop_e aluop, input alusel_e alusel);
		reg_addr_t   rs;
		reg_addr_t   rt;
		logic [15:0] imm;
		word_t       expected_imm;
		rs  = (op == OP_LUI) ? 5'd0 : random_reg();
		rt  = random_reg();
		imm = 16'($urandom);
		if (op inside {OP_ANDI, OP_ORI, OP_XORI}) begin
			expected_imm = {16'h0, imm};
		end else if (op == OP_LUI) begin
			expected_imm = {imm, 16'h0};
		end else begin
			expected_imm = sign_ext16(imm);
		end
		inst = i_inst(op, rs, rt, imm);
		next_cycle();
		check_value("rf2_o.read", 1'b0, rf2.read);
		check_ex(aluop, alusel, 1'b1, rt, rf_value(rs));
		check_value("ex_o.reg2", expected_imm, ex_out.reg2);
	endtask

	task automatic test_load(input opcode_e op, input aluop_e aluop);
		reg_addr_t rs;
		reg_addr_t rt;
		rs   = random_reg();
		rt   = random_reg();
		inst = i_inst(op, rs, rt, 16'($urandom));
		next_cycle();
		check_ex(aluop, SEL_LOAD_STORE, 1'b1, rt, rf_value(rs));
	endtask

	task automatic test_store(input opcode_e op, input aluop_e aluop);
		reg_addr_t rs;
		reg_addr_t rt;
		rs   = random_reg();
		rt   = random_reg();
		inst = i_inst(op, rs, rt, 16'($urandom));
		next_cycle();
		check_value("ex_o.aluop", aluop, ex_out.aluop);
		check_value("ex_o.alusel", SEL_LOAD_STORE, ex_out.alusel);
		check_value("ex_o.wreg", 1'b0, ex_out.wreg);
		check_value("ex_o.reg1", rf_value(rs), ex_out.reg1);
		check_value("ex_o.reg2", rf_value(rt), ex_out.reg2);
	endtask

	task automatic test_alu_decode();
		repeat (decode_rounds) begin
			test_r_form(FN_ADDU, ALU_ADDU, SEL_ARITH);
			test_r_form(FN_SUB, ALU_SUB, SEL_ARITH);
			test_r_form(FN_AND, ALU_AND, SEL_LOGIC);
			test_r_form(FN_NOR, ALU_NOR, SEL_LOGIC);
			test_r_form(FN_SLT, ALU_SLT, SEL_ARITH);
			test_r_form(FN_SRLV, ALU_SRL, SEL_SHIFT);
			test_const_shift(FN_SLL, ALU_SLL);
			test_const_shift(FN_SRL, ALU_SRL);
			test_const_shift(FN_SRA, ALU_SRA);
			test_imm_form(OP_ANDI, ALU_AND, SEL_LOGIC);
			test_imm_form(OP_ORI, ALU_OR, SEL_LOGIC);
			test_imm_form(OP_XORI, ALU_XOR, SEL_LOGIC);
			test_imm_form(OP_LUI, ALU_OR, SEL_LOGIC);
			test_imm_form(OP_ADDI, ALU_ADDI, SEL_ARITH);
			test_imm_form(OP_ADDIU, ALU_ADDIU, SEL_ARITH);
			test_imm_form(OP_SLTI, ALU_SLT, SEL_ARITH);
			test_imm_form(OP_SLTIU, ALU_SLTU, SEL_ARITH);
			test_load(OP_LB, ALU_LB);
			test_load(OP_LBU, ALU_LBU);
			test_load(OP_LH, ALU_LH);
			test_load(OP_LHU, ALU_LHU);
			test_load(OP_LW, ALU_LW);
			test_store(OP_SB, ALU_SB);
			test_store(OP_SH, ALU_SH);
			test_store(OP_SW, ALU_SW);
		end
	endtask

	task automatic test_forwarding();
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t rd;
		word_t     ex_data;
		word_t     mem_data;
		rs       = random_reg();
		rt       = rs ^ 5'd1;
		rd       = random_reg();
		ex_data  = $urandom;
		mem_data = $urandom;
		ex_aluop = ALU_ADDU;
		// both stages write rs
		ex_fwd   = '{wreg: 1'b1, addr: rs, data: ex_data};
		mem_fwd  = '{wreg: 1'b1, addr: rs, data: mem_data};
		inst     = r_inst(FN_ADDU, rs, rt, rd, 5'd0);
		next_cycle();
		check_value("ex_o.reg1", ex_data, ex_out.reg1);
		check_value("ex_o.reg2", rf_value(rt), ex_out.reg2);
		// same address in ex, but no write there
		ex_fwd.wreg = 1'b0;
		next_cycle();
		check_value("ex_o.reg1", mem_data, ex_out.reg1);
		clear_forwarding();
	endtask

	task automatic test_load_use();
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t rd;
		rs       = random_reg();
		rt       = rs ^ 5'd1;
		rd       = random_reg();
		ex_aluop = ALU_LW;
		ex_fwd   = '{wreg: 1'b1, addr: rs, data: $urandom};
		inst     = r_inst(FN_ADDU, rs, rt, rd, 5'd0);
		@(posedge clk);
		check_value("stall_o", 1'b1, stall);
		@(negedge clk);
		check_value("ex_o.wreg", 1'b0, ex_out.wreg);
		check_value("ex_o.aluop", ALU_NOP, ex_out.aluop);
		clear_forwarding();
		@(posedge clk);
		check_value("stall_o", 1'b0, stall);
		@(negedge clk);
		check_ex(ALU_ADDU, SEL_ARITH, 1'b1, rd, rf_value(rs));
	endtask

	task automatic test_branches();
		reg_addr_t   rs;
		reg_addr_t   rt;
		logic [15:0] off;
		word_t       target;
		rs     = random_reg();
		rt     = rs ^ 5'd1;
		off    = 16'($urandom);
		pc     = $urandom & 32'hffff_fffc;
		target = pc + 32'd4 + (sign_ext16(off) << 2);
		inst = i_inst(OP_BEQ, rs, rs, off);
		check_branch(1'b1, target);
		inst = i_inst(OP_BEQ, rs, rt, off);
		check_branch(1'b0, target);
		inst = i_inst(OP_BNE, rs, rt, off);
		check_branch(1'b1, target);
		inst = i_inst(OP_BNE, rs, rs, off);
		check_branch(1'b0, target);
		// register file values are all non-negative
		inst = i_inst(OP_REGIMM, rs, RI_BGEZ, off);
		check_branch(1'b1, target);
		inst = i_inst(OP_REGIMM, rs, RI_BLTZ, off);
		check_branch(1'b0, target);
		ex_aluop = ALU_ADDU;
		ex_fwd   = '{wreg: 1'b1, addr: rs, data: 32'h8000_0000 | $urandom};
		inst = i_inst(OP_REGIMM, rs, RI_BLTZ, off);
		check_branch(1'b1, target);
		inst = i_inst(OP_REGIMM, rs, RI_BGEZ, off);
		check_branch(1'b0, target);
		clear_forwarding();
	endtask

	task automatic test_jal();
		logic [25:0] index;
		word_t       pc_plus_4;
		index     = 26'($urandom);
		pc        = $urandom & 32'hffff_fffc;
		pc_plus_4 = pc + 32'd4;
		inst      = {OP_JAL, index};
		check_branch(1'b1, {pc_plus_4[31:28], index, 2'b00});
		check_value("ex_o.aluop", ALU_JAL, ex_out.aluop);
		check_value("ex_o.alusel", SEL_JUMP_BRANCH, ex_out.alusel);
		check_value("ex_o.wreg", 1'b1, ex_out.wreg);
		check_value("ex_o.wd", 5'd31, ex_out.wd);
		check_value("ex_o.link_addr", pc + 32'd8, ex_out.link_addr);
	endtask

	task automatic test_jr();
		reg_addr_t rs;
		word_t     dest;
		rs       = random_reg();
		dest     = $urandom & 32'hffff_fffc;
		ex_aluop = ALU_ADDU;
		ex_fwd   = '{wreg: 1'b1, addr: rs, data: dest};
		inst     = r_inst(FN_JR, rs, 5'd0, 5'd0, 5'd0);
		check_branch(1'b1, dest);
		clear_forwarding();
	endtask

	task automatic test_delay_slot();
		in_delay_slot = 1'b1;
		inst          = r_inst(FN_OR, random_reg(), random_reg(), random_reg(), 5'd0);
		next_cycle();
		check_value("ex_o.in_delay_slot", 1'b1, ex_out.in_delay_slot);
		check_value("ex_o.inst", inst, ex_out.inst);
		in_delay_slot = 1'b0;
	endtask

	//////////////////////////////////////////////////
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= timeout_cycles) begin
			$display("Timeout: the tests did not finish within %0d cycles", timeout_cycles);
			$display("Simulation failed");
			$fatal(1, "timeout");
		end
	end

	initial begin
		void'($urandom(91));
		pc            = '0;
		inst          = '0;
		ex_fwd        = '0;
		mem_fwd       = '0;
		ex_aluop      = ALU_NOP;
		in_delay_slot = 1'b0;
		@(negedge reset);
		test_reset();
		test_alu_decode();
		test_forwarding();
		test_load_use();
		test_branches();
		test_jal();
		test_jr();
		test_delay_slot();
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

// File: testbench/id_stage_checker.sv
`timescale 1ns/1ps

module id_stage_checker (
	input logic                     clk_i,
	input logic                     reset_i,
	input logic                     stall_i,
	input logic                     branch_flag_i,
	input logic                     next_in_delay_slot_i,
	input id_stage_pkg::ex_bundle_t ex_i
);

	// a stalled instruction never reaches execute
	stall_gives_bubble: assert property (@(posedge clk_i) disable iff (reset_i)
		stall_i |=> !ex_i.wreg)
		else $error("stall was not followed by a bubble in ex_o");

	taken_branch_has_slot: assert property (@(posedge clk_i) disable iff (reset_i)
		branch_flag_i |-> next_in_delay_slot_i)
		else $error("branch taken without a delay slot flag");

	reset_gives_bubble: assert property (@(posedge clk_i)
		reset_i |=> !ex_i.wreg)
		else $error("ex_o writes a register right after reset");

endmodule

bind id_stage id_stage_checker checker_i (
	.clk_i                (clk_i),
	.reset_i              (reset_i),
	.stall_i              (stall_o),
	.branch_flag_i        (branch_flag_o),
	.next_in_delay_slot_i (next_in_delay_slot_o),
	.ex_i                 (ex_o)
);

// File: testbench/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
	output logic clk_o,
	output logic reset_o
);

	// 20 ns period
	initial begin
		clk_o = 1'b0;
		forever #10 clk_o = ~clk_o;
	end

	initial begin
		reset_o = 1'b1;
		repeat (5) @(posedge clk_o);
		@(negedge clk_o);
		reset_o = 1'b0;
	end

endmodule

// File: source/id_stage.sv
`timescale 1ns/1ps

module id_stage (
	input  logic                     clk_i,
	input  logic                     reset_i,
	input  mips_isa_pkg::word_t      pc_i,
	input  mips_isa_pkg::word_t      inst_i,
	input  mips_isa_pkg::word_t      reg1_data_i,
	input  mips_isa_pkg::word_t      reg2_data_i,
	input  id_stage_pkg::fwd_t       ex_fwd_i,
	input  id_stage_pkg::fwd_t       mem_fwd_i,
	input  id_stage_pkg::aluop_e     ex_aluop_i,
	input  logic                     in_delay_slot_i,
	output id_stage_pkg::rf_req_t    rf1_o,
	output id_stage_pkg::rf_req_t    rf2_o,
	output logic                     stall_o,
	output logic                     branch_flag_o,
	output mips_isa_pkg::word_t      branch_target_o,
	output logic                     next_in_delay_slot_o,
	output id_stage_pkg::ex_bundle_t ex_o
);
	import mips_isa_pkg::*;
	import id_stage_pkg::*;

	dec_ctrl_t  ctrl;
	word_t      reg1;
	word_t      reg2;
	word_t      link_addr;
	logic       stall1;
	logic       stall2;
	ex_bundle_t next_bundle;

	id_decoder decoder (
		.inst_i (inst_i),
		.ctrl_o (ctrl)
	);

	assign rf1_o = ctrl.rf1;
	assign rf2_o = ctrl.rf2;

	//////////////////////////////////////////////////
	// operands with forwarding
	id_operand_select operand1 (
		.req_i      (ctrl.rf1),
		.rf_data_i  (reg1_data_i),
		.imm_i      (ctrl.imm),
		.ex_fwd_i   (ex_fwd_i),
		.mem_fwd_i  (mem_fwd_i),
		.ex_aluop_i (ex_aluop_i),
		.operand_o  (reg1),
		.stall_o    (stall1)
	);

	id_operand_select operand2 (
		.req_i      (ctrl.rf2),
		.rf_data_i  (reg2_data_i),
		.imm_i      (ctrl.imm),
		.ex_fwd_i   (ex_fwd_i),
		.mem_fwd_i  (mem_fwd_i),
		.ex_aluop_i (ex_aluop_i),
		.operand_o  (reg2),
		.stall_o    (stall2)
	);

	assign stall_o = stall1 | stall2;

	id_branch_unit branch_unit (
		.branch_i             (ctrl.branch),
		.pc_i                 (pc_i),
		.inst_i               (inst_i),
		.reg1_i               (reg1),
		.reg2_i               (reg2),
		.branch_flag_o        (branch_flag_o),
		.branch_target_o      (branch_target_o),
		.link_addr_o          (link_addr),
		.next_in_delay_slot_o (next_in_delay_slot_o)
	);

	//////////////////////////////////////////////////
	// decode to execute boundary
	assign next_bundle = '{
		aluop:         ctrl.aluop,
		alusel:        ctrl.alusel,
		reg1:          reg1,
		reg2:          reg2,
		wd:            ctrl.wd,
		wreg:          ctrl.wreg,
		link_addr:     link_addr,
		inst:          inst_i,
		in_delay_slot: in_delay_slot_i
	};

	id_ex_register ex_register (
		.clk_i   (clk_i),
		.reset_i (reset_i),
		.stall_i (stall_o),
		.next_i  (next_bundle),
		.ex_o    (ex_o)
	);

endmodule

// File: source/id_ex_register.sv
`timescale 1ns/1ps

module id_ex_register (
	input  logic                     clk_i,
	input  logic                     reset_i,
	input  logic                     stall_i,
	input  id_stage_pkg::ex_bundle_t next_i,
	output id_stage_pkg::ex_bundle_t ex_o
);

	// an all-zero bundle is a nop bubble with no write
	always_ff @(posedge clk_i) begin
		if (reset_i || stall_i) begin
			ex_o <= '0;
		end else begin
			ex_o <= next_i;
		end
	end

endmodule

// File: source/id_branch_unit.sv
`timescale 1ns/1ps

module id_branch_unit (
	input  id_stage_pkg::branch_e branch_i,
	input  mips_isa_pkg::word_t   pc_i,
	input  mips_isa_pkg::word_t   inst_i,
	input  mips_isa_pkg::word_t   reg1_i,
	input  mips_isa_pkg::word_t   reg2_i,
	output logic                  branch_flag_o,
	output mips_isa_pkg::word_t   branch_target_o,
	output mips_isa_pkg::word_t   link_addr_o,
	output logic                  next_in_delay_slot_o
);
	import mips_isa_pkg::*;
	import id_stage_pkg::*;

	word_t pc_plus_4;
	word_t pc_plus_8;
	word_t offset;
	word_t target;
	logic  reg1_neg;
	logic  reg1_zero;

	assign pc_plus_4 = pc_i + 32'd4;
	assign pc_plus_8 = pc_i + 32'd8;
	assign offset    = {{14{inst_i[15]}}, inst_i[15:0], 2'b00};
	assign reg1_neg  = reg1_i[word_width-1];
	assign reg1_zero = (reg1_i == '0);

	always_comb begin
		branch_flag_o = 1'b0;
		target        = pc_plus_4 + offset;
		case (branch_i)
			BR_J, BR_JAL: begin
				branch_flag_o = 1'b1;
				target        = {pc_plus_4[31:28], inst_i[25:0], 2'b00};
			end
			BR_JR, BR_JALR: begin
				branch_flag_o = 1'b1;
				target        = reg1_i;
			end
			BR_BEQ:               branch_flag_o = (reg1_i == reg2_i);
			BR_BNE:               branch_flag_o = (reg1_i != reg2_i);
			BR_BGTZ:              branch_flag_o = !reg1_neg && !reg1_zero;
			BR_BLEZ:              branch_flag_o = reg1_neg || reg1_zero;
			BR_BGEZ, BR_BGEZAL:   branch_flag_o = !reg1_neg;
			BR_BLTZ, BR_BLTZAL:   branch_flag_o = reg1_neg;
			default: ;
		endcase
	end

	// target reads zero when not taken
	assign branch_target_o = branch_flag_o ? target : '0;
	assign link_addr_o = (branch_i inside {BR_JAL, BR_JALR, BR_BGEZAL, BR_BLTZAL}) ?
		pc_plus_8 : '0;
	assign next_in_delay_slot_o = (branch_i != BR_NONE);

endmodule

// File: source/id_operand_select.sv
`timescale 1ns/1ps

module id_operand_select (
	input  id_stage_pkg::rf_req_t req_i,
	input  mips_isa_pkg::word_t   rf_data_i,
	input  mips_isa_pkg::word_t   imm_i,
	input  id_stage_pkg::fwd_t    ex_fwd_i,
	input  id_stage_pkg::fwd_t    mem_fwd_i,
	input  id_stage_pkg::aluop_e  ex_aluop_i,
	output mips_isa_pkg::word_t   operand_o,
	output logic                  stall_o
);
	import id_stage_pkg::*;

	logic ex_match;
	logic mem_match;

	// r0 is compared like any other register
	assign ex_match  = req_i.read && (ex_fwd_i.addr == req_i.addr);
	assign mem_match = req_i.read && mem_fwd_i.wreg && (mem_fwd_i.addr == req_i.addr);

	always_comb begin
		stall_o   = 1'b0;
		operand_o = imm_i;
		if (ex_match && aluop_is_load(ex_aluop_i)) begin
			// load result not ready until mem
			stall_o   = 1'b1;
			operand_o = '0;
		end else if (ex_match && ex_fwd_i.wreg) begin
			operand_o = ex_fwd_i.data;
		end else if (mem_match) begin
			operand_o = mem_fwd_i.data;
		end else if (req_i.read) begin
			operand_o = rf_data_i;
		end
	end

endmodule

// File: source/id_decoder.sv
`timescale 1ns/1ps

module id_decoder (
	input  mips_isa_pkg::word_t     inst_i,
	output id_stage_pkg::dec_ctrl_t ctrl_o
);
	import mips_isa_pkg::*;
	import id_stage_pkg::*;

	opcode_e                opcode;
	funct_e                 funct;
	regimm_e                regimm;
	reg_addr_t              rs;
	reg_addr_t              rt;
	reg_addr_t              rd;
	logic [shamt_width-1:0] shamt;
	logic [imm_width-1:0]   imm16;
	word_t                  imm_zext;
	word_t                  imm_sext;
	word_t                  shamt_ext;

	assign opcode = opcode_e'(inst_i[31:26]);
	assign funct  = funct_e'(inst_i[5:0]);
	assign regimm = regimm_e'(inst_i[20:16]);
	assign rs     = inst_i[25:21];
	assign rt     = inst_i[20:16];
	assign rd     = inst_i[15:11];
	assign shamt  = inst_i[10:6];
	assign imm16  = inst_i[15:0];

	assign imm_zext  = {{(word_width-imm_width){1'b0}}, imm16};
	assign imm_sext  = {{(word_width-imm_width){imm16[imm_width-1]}}, imm16};
	assign shamt_ext = {{(word_width-shamt_width){1'b0}}, shamt};

	always_comb begin
		// unknown encodings stay a nop reading rs and rt
		ctrl_o     = '0;
		ctrl_o.wd  = rd;
		ctrl_o.rf1 = '{read: 1'b1, addr: rs};
		ctrl_o.rf2 = '{read: 1'b1, addr: rt};

		//////////////////////////////////////////////////
		// operation
		case (opcode)
			OP_SPECIAL: begin
				case (funct)
					FN_AND:          ctrl_o.aluop = ALU_AND;
					FN_OR:           ctrl_o.aluop = ALU_OR;
					FN_XOR:          ctrl_o.aluop = ALU_XOR;
					FN_NOR:          ctrl_o.aluop = ALU_NOR;
					FN_SLL, FN_SLLV: ctrl_o.aluop = ALU_SLL;
					FN_SRL, FN_SRLV: ctrl_o.aluop = ALU_SRL;
					FN_SRA, FN_SRAV: ctrl_o.aluop = ALU_SRA;
					FN_ADD:          ctrl_o.aluop = ALU_ADD;
					FN_ADDU:         ctrl_o.aluop = ALU_ADDU;
					FN_SUB:          ctrl_o.aluop = ALU_SUB;
					FN_SUBU:         ctrl_o.aluop = ALU_SUBU;
					FN_SLT:          ctrl_o.aluop = ALU_SLT;
					FN_SLTU:         ctrl_o.aluop = ALU_SLTU;
					FN_JR:           ctrl_o.aluop = ALU_JR;
					FN_JALR:         ctrl_o.aluop = ALU_JALR;
					default:         ctrl_o.aluop = ALU_NOP;
				endcase
				ctrl_o.wreg = !(ctrl_o.aluop inside {ALU_NOP, ALU_JR});
				// sa replaces rs for the constant shifts
				if (funct inside {FN_SLL, FN_SRL, FN_SRA}) begin
					ctrl_o.rf1.read = 1'b0;
					ctrl_o.imm      = shamt_ext;
				end
				if (funct inside {FN_JR, FN_JALR}) begin
					ctrl_o.rf2.read = 1'b0;
				end
			end
			OP_REGIMM: begin
				ctrl_o.rf2.read = 1'b0;
				case (regimm)
					RI_BLTZ:   ctrl_o.aluop = ALU_BLTZ;
					RI_BGEZ:   ctrl_o.aluop = ALU_BGEZ;
					RI_BLTZAL: ctrl_o.aluop = ALU_BLTZAL;
					RI_BGEZAL: ctrl_o.aluop = ALU_BGEZAL;
					default:   ctrl_o.rf2.read = 1'b1;
				endcase
			end
			OP_ANDI:        ctrl_o.aluop = ALU_AND;
			OP_ORI, OP_LUI: ctrl_o.aluop = ALU_OR;
			OP_XORI:        ctrl_o.aluop = ALU_XOR;
			OP_ADDI:        ctrl_o.aluop = ALU_ADDI;
			OP_ADDIU:       ctrl_o.aluop = ALU_ADDIU;
			OP_SLTI:        ctrl_o.aluop = ALU_SLT;
			OP_SLTIU:       ctrl_o.aluop = ALU_SLTU;
			OP_LB:          ctrl_o.aluop = ALU_LB;
			OP_LBU:         ctrl_o.aluop = ALU_LBU;
			OP_LH:          ctrl_o.aluop = ALU_LH;
			OP_LHU:         ctrl_o.aluop = ALU_LHU;
			OP_LW:          ctrl_o.aluop = ALU_LW;
			OP_SB:          ctrl_o.aluop = ALU_SB;
			OP_SH:          ctrl_o.aluop = ALU_SH;
			OP_SW:          ctrl_o.aluop = ALU_SW;
			OP_J:           ctrl_o.aluop = ALU_J;
			OP_JAL:         ctrl_o.aluop = ALU_JAL;
			OP_BEQ:         ctrl_o.aluop = ALU_BEQ;
			OP_BNE:         ctrl_o.aluop = ALU_BNE;
			OP_BLEZ:        ctrl_o.aluop = ALU_BLEZ;
			OP_BGTZ:        ctrl_o.aluop = ALU_BGTZ;
			default:        ctrl_o.aluop = ALU_NOP;
		endcase

		//////////////////////////////////////////////////
		// operands and destination
		if (opcode inside {OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_ADDI, OP_ADDIU,
				OP_SLTI, OP_SLTIU, OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW}) begin
			ctrl_o.wreg     = 1'b1;
			ctrl_o.wd       = rt;
			ctrl_o.rf2.read = 1'b0;
		end
		case (opcode)
			OP_ANDI, OP_ORI, OP_XORI:            ctrl_o.imm = imm_zext;
			OP_LUI:                              ctrl_o.imm = {imm16, 16'h0};
			OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU: ctrl_o.imm = imm_sext;
			default: ;
		endcase
		if (opcode inside {OP_J, OP_JAL}) begin
			ctrl_o.rf1.read = 1'b0;
			ctrl_o.rf2.read = 1'b0;
		end
		if (opcode inside {OP_BLEZ, OP_BGTZ}) begin
			ctrl_o.rf2.read = 1'b0;
		end
		if (ctrl_o.aluop inside {ALU_JAL, ALU_BGEZAL, ALU_BLTZAL}) begin
			ctrl_o.wreg = 1'b1;
			ctrl_o.wd   = link_reg;
		end

		// result class and branch kind follow the operation
		case (ctrl_o.aluop)
			ALU_NOP:                           ctrl_o.alusel = SEL_NOP;
			ALU_OR, ALU_AND, ALU_XOR, ALU_NOR: ctrl_o.alusel = SEL_LOGIC;
			ALU_SLL, ALU_SRL, ALU_SRA:         ctrl_o.alusel = SEL_SHIFT;
			ALU_SLT, ALU_SLTU, ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_ADDI, ALU_ADDIU:
				ctrl_o.alusel = SEL_ARITH;
			ALU_LB, ALU_LBU, ALU_LH, ALU_LHU, ALU_LW, ALU_SB, ALU_SH, ALU_SW:
				ctrl_o.alusel = SEL_LOAD_STORE;
			default:                           ctrl_o.alusel = SEL_JUMP_BRANCH;
		endcase
		case (ctrl_o.aluop)
			ALU_J:      ctrl_o.branch = BR_J;
			ALU_JAL:    ctrl_o.branch = BR_JAL;
			ALU_JR:     ctrl_o.branch = BR_JR;
			ALU_JALR:   ctrl_o.branch = BR_JALR;
			ALU_BEQ:    ctrl_o.branch = BR_BEQ;
			ALU_BNE:    ctrl_o.branch = BR_BNE;
			ALU_BGTZ:   ctrl_o.branch = BR_BGTZ;
			ALU_BLEZ:   ctrl_o.branch = BR_BLEZ;
			ALU_BGEZ:   ctrl_o.branch = BR_BGEZ;
			ALU_BLTZ:   ctrl_o.branch = BR_BLTZ;
			ALU_BGEZAL: ctrl_o.branch = BR_BGEZAL;
			ALU_BLTZAL: ctrl_o.branch = BR_BLTZAL;
			default:    ctrl_o.branch = BR_NONE;
		endcase
	end

endmodule

// File: source/id_stage_pkg.sv
package id_stage_pkg;

	//////////////////////////////////////////////////
	// operation passed on to execute
	typedef enum logic [7:0] {
		ALU_NOP    = 8'b00000000,
		ALU_OR     = 8'b00100101,
		ALU_AND    = 8'b00100100,
		ALU_XOR    = 8'b00100110,
		ALU_NOR    = 8'b00100111,
		ALU_SLL    = 8'b01111100,
		ALU_SRL    = 8'b00000010,
		ALU_SRA    = 8'b00000011,
		ALU_SLT    = 8'b00101010,
		ALU_SLTU   = 8'b00101011,
		ALU_ADD    = 8'b00100000,
		ALU_ADDU   = 8'b00100001,
		ALU_SUB    = 8'b00100010,
		ALU_SUBU   = 8'b00100011,
		ALU_ADDI   = 8'b01010101,
		ALU_ADDIU  = 8'b01010110,
		ALU_J      = 8'b01001111,
		ALU_JAL    = 8'b01010000,
		ALU_JR     = 8'b00001000,
		ALU_JALR   = 8'b00001001,
		ALU_BEQ    = 8'b01010001,
		ALU_BNE    = 8'b01010010,
		ALU_BGTZ   = 8'b01010100,
		ALU_BLEZ   = 8'b01010011,
		ALU_BGEZ   = 8'b01000001,
		ALU_BLTZ   = 8'b01000000,
		ALU_BGEZAL = 8'b01001011,
		ALU_BLTZAL = 8'b01001010,
		ALU_LB     = 8'b11100000,
		ALU_LBU    = 8'b11100100,
		ALU_LH     = 8'b11100001,
		ALU_LHU    = 8'b11100101,
		ALU_LW     = 8'b11100011,
		ALU_SB     = 8'b11101000,
		ALU_SH     = 8'b11101001,
		ALU_SW     = 8'b11101011
	} aluop_e;

	typedef enum logic [2:0] {
		SEL_NOP         = 3'b000,
		SEL_LOGIC       = 3'b001,
		SEL_SHIFT       = 3'b010,
		SEL_ARITH       = 3'b100,
		SEL_JUMP_BRANCH = 3'b110,
		SEL_LOAD_STORE  = 3'b111
	} alusel_e;

	typedef enum logic [3:0] {
		BR_NONE, BR_J, BR_JAL, BR_JR, BR_JALR, BR_BEQ, BR_BNE,
		BR_BGTZ, BR_BLEZ, BR_BGEZ, BR_BLTZ, BR_BGEZAL, BR_BLTZAL
	} branch_e;

	//////////////////////////////////////////////////
	typedef struct packed {
		logic                    read;
		mips_isa_pkg::reg_addr_t addr;
	} rf_req_t;

	// write seen in a later stage
	typedef struct packed {
		logic                    wreg;
		mips_isa_pkg::reg_addr_t addr;
		mips_isa_pkg::word_t     data;
	} fwd_t;

	typedef struct packed {
		aluop_e                  aluop;
		alusel_e                 alusel;
		logic                    wreg;
		mips_isa_pkg::reg_addr_t wd;
		mips_isa_pkg::word_t     imm;
		branch_e                 branch;
		rf_req_t                 rf1;
		rf_req_t                 rf2;
	} dec_ctrl_t;

	typedef struct packed {
		aluop_e                  aluop;
		alusel_e                 alusel;
		mips_isa_pkg::word_t     reg1;
		mips_isa_pkg::word_t     reg2;
		mips_isa_pkg::reg_addr_t wd;
		logic                    wreg;
		mips_isa_pkg::word_t     link_addr;
		mips_isa_pkg::word_t     inst;
		logic                    in_delay_slot;
	} ex_bundle_t;

	function automatic logic aluop_is_load(aluop_e op);
		return op inside {ALU_LB, ALU_LBU, ALU_LH, ALU_LHU, ALU_LW};
	endfunction

endpackage

// File: source/mips_isa_pkg.sv
package mips_isa_pkg;

	localparam int word_width     = 32;
	localparam int reg_addr_width = 5;
	localparam int opcode_width   = 6;
	localparam int funct_width    = 6;
	localparam int shamt_width    = 5;
	localparam int imm_width      = 16;

	typedef logic [word_width-1:0]     word_t;
	typedef logic [reg_addr_width-1:0] reg_addr_t;

	// destination of jal and the -al branches
	localparam reg_addr_t link_reg = 5'd31;

	//////////////////////////////////////////////////
	// primary opcode, inst[31:26]
	typedef enum logic [opcode_width-1:0] {
		OP_SPECIAL = 6'b000000,
		OP_REGIMM  = 6'b000001,
		OP_J       = 6'b000010,
		OP_JAL     = 6'b000011,
		OP_BEQ     = 6'b000100,
		OP_BNE     = 6'b000101,
		OP_BLEZ    = 6'b000110,
		OP_BGTZ    = 6'b000111,
		OP_ADDI    = 6'b001000,
		OP_ADDIU   = 6'b001001,
		OP_SLTI    = 6'b001010,
		OP_SLTIU   = 6'b001011,
		OP_ANDI    = 6'b001100,
		OP_ORI     = 6'b001101,
		OP_XORI    = 6'b001110,
		OP_LUI     = 6'b001111,
		OP_LB      = 6'b100000,
		OP_LH      = 6'b100001,
		OP_LW      = 6'b100011,
		OP_LBU     = 6'b100100,
		OP_LHU     = 6'b100101,
		OP_SB      = 6'b101000,
		OP_SH      = 6'b101001,
		OP_SW      = 6'b101011
	} opcode_e;

	// special function code, inst[5:0]
	typedef enum logic [funct_width-1:0] {
		FN_SLL  = 6'b000000,
		FN_SRL  = 6'b000010,
		FN_SRA  = 6'b000011,
		FN_SLLV = 6'b000100,
		FN_SRLV = 6'b000110,
		FN_SRAV = 6'b000111,
		FN_JR   = 6'b001000,
		FN_JALR = 6'b001001,
		FN_ADD  = 6'b100000,
		FN_ADDU = 6'b100001,
		FN_SUB  = 6'b100010,
		FN_SUBU = 6'b100011,
		FN_AND  = 6'b100100,
		FN_OR   = 6'b100101,
		FN_XOR  = 6'b100110,
		FN_NOR  = 6'b100111,
		FN_SLT  = 6'b101010,
		FN_SLTU = 6'b101011
	} funct_e;

	// regimm code in the rt field
	typedef enum logic [reg_addr_width-1:0] {
		RI_BLTZ   = 5'b00000,
		RI_BGEZ   = 5'b00001,
		RI_BLTZAL = 5'b10000,
		RI_BGEZAL = 5'b10001
	} regimm_e;

endpackage
